// File: design/vmem_pkg.sv
/* widths, map word layout and processor phases shared by the design
   map word is {access, write, phys_page}, single-level map only */
`default_nettype none

package vmem_pkg;

   localparam int PAGE_W   = 4;
   localparam int OFFSET_W = 8;
   localparam int PPAGE_W  = 3;
   localparam int WORD_W   = 16;

   typedef logic [PAGE_W+OFFSET_W-1:0]  vaddr_t;
   typedef logic [PAGE_W-1:0]           page_t;
   typedef logic [PPAGE_W-1:0]          ppage_t;
   typedef logic [PPAGE_W+OFFSET_W-1:0] paddr_t;
   typedef logic [WORD_W-1:0]           word_t;
   typedef logic [PPAGE_W+1:0]          map_entry_t;

   // flags sit just above the physical page
   localparam int MAP_WRITE_BIT  = PPAGE_W;
   localparam int MAP_ACCESS_BIT = PPAGE_W + 1;

   // processor phase ring in ring order
   typedef enum logic [1:0]
   {
      st_alu,
      st_write,
      st_fetch,
      st_prefetch
   } cpu_state_t;

endpackage

`default_nettype wire

// File: design/cpu_state_ring.sv
/* four-phase processor ring, starts in alu after reset
   holds in fetch for as long as waiting stays high */
`timescale 1ns/100ps
`default_nettype none

module cpu_state_ring
(
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  waiting,
   output vmem_pkg::cpu_state_t state
);
   import vmem_pkg::*;

   cpu_state_t state_next;

   always_comb
   begin
      case (state)
         st_alu:
            state_next = st_write;
         st_write:
            state_next = st_fetch;
         // memory cycle stall
         st_fetch:
            state_next = waiting ? st_fetch : st_prefetch;
         st_prefetch:
            state_next = st_alu;
         default:
            state_next = st_alu;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= st_alu;
      else
         state <= state_next;
   end

   // one phase per cycle with a repeat only on a fetch stall or out of reset
   a_ring_step: assert property (@(posedge clk) disable iff (reset)
      $past(reset) ||
      (state == cpu_state_t'($past(state) + 2'd1)) ||
      ((state == st_fetch) && $past(state == st_fetch) && $past(waiting)));

endmodule

`default_nettype wire

// File: design/vmem_map.sv
/* 16-entry page map, async read, sync write
   after reset it sweeps all entries to invalid over 16 cycles;
   map writes must wait until the sweep is over */
`timescale 1ns/100ps
`default_nettype none

module vmem_map
(
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  map_wr,
   input  wire vmem_pkg::page_t map_page,
   input  wire vmem_pkg::map_entry_t map_data,
   input  wire vmem_pkg::page_t page,
   output logic                 access_ok,
   output logic                 write_ok,
   output vmem_pkg::ppage_t     phys_page
);
   import vmem_pkg::*;

   localparam int ENTRIES = 2 ** PAGE_W;

   map_entry_t map_ram [ENTRIES];
   map_entry_t entry;
   page_t      sweep_page;
   logic       sweeping;

   // sweep pointer steps one entry per cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sweeping   <= 1'b1;
         sweep_page <= '0;
      end
      else if (sweeping)
      begin
         sweep_page <= sweep_page + 1'b1;
         if (sweep_page == page_t'(ENTRIES - 1))
            sweeping <= 1'b0;
      end
   end

   // sweep has the port while it runs
   always_ff @(posedge clk)
   begin
      if (sweeping)
         map_ram[sweep_page] <= '0;
      else if (map_wr)
         map_ram[map_page] <= map_data;
   end

   // lookup for the page under access
   assign entry     = map_ram[page];
   assign access_ok = entry[MAP_ACCESS_BIT];
   assign write_ok  = entry[MAP_WRITE_BIT];
   assign phys_page = entry[PPAGE_W-1:0];

   // loader must wait out the sweep
   a_no_write_in_sweep: assert property (@(posedge clk) disable iff (reset)
      sweeping |-> !map_wr);

endmodule

`default_nettype wire

// File: design/vmem_ctrl.sv
/* memory cycle control: prepare, start, check, then a read or write cycle
   a request is taken once in the alu phase and must be held until
   done or fault, then dropped for a cycle before the next one */
`timescale 1ns/100ps
`default_nettype none

module vmem_ctrl
(
   input  wire                       clk,
   input  wire                       reset,
   input  wire vmem_pkg::cpu_state_t state,
   input  wire                       mem_rd,
   input  wire                       mem_wr,
   input  wire                       access_ok,
   input  wire                       write_ok,
   input  wire                       memack,
   output logic                      memprepare,
   output logic                      memstart,
   output logic                      memcheck,
   output logic                      memrq,
   output logic                      rdcyc,
   output logic                      wrcyc,
   output logic                      vmaok,
   output logic                      mbusy,
   output logic                      waiting
);
   import vmem_pkg::*;

   logic memop;
   logic taken;
   logic pfr;
   logic pfw;
   logic check_end;

   assign memop = mem_rd | mem_wr;

   // held request counts once and is rearmed when it drops
   always_ff @(posedge clk)
   begin
      if (reset || !memop)
         taken <= 1'b0;
      else if (state == st_alu)
         taken <= 1'b1;
   end

   // prepare spans the alu and write phases
   always_ff @(posedge clk)
   begin
      if (reset)
         memprepare <= 1'b0;
      else
         memprepare <= ((state == st_alu) && memop && !taken) ||
                       ((state == st_write) && memprepare);
   end

   // map read then map check
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         memstart <= 1'b0;
         memcheck <= 1'b0;
      end
      else
      begin
         memstart <= (state != st_alu) && memprepare;
         memcheck <= memstart;
      end
   end

   assign pfr = access_ok & ~wrcyc;
   assign pfw = access_ok & write_ok & wrcyc;

   // last check cycle where the cycle flags are valid
   assign check_end = memcheck & ~memstart;

   always_ff @(posedge clk)
   begin
      if (reset)
         vmaok <= 1'b0;
      else if (memcheck)
         vmaok <= pfr | pfw;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end
      else if ((state == st_fetch || state == st_prefetch) && memstart && memcheck)
      begin
         rdcyc <= mem_rd;
         wrcyc <= mem_wr;
      end
      else if ((!memrq && !memprepare && !memstart) || memack)
      begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end
   end

   assign memrq = mbusy | (check_end & (pfr | pfw));

   always_ff @(posedge clk)
   begin
      if (reset || memack)
         mbusy <= 1'b0;
      else if (check_end && (pfr || pfw))
         mbusy <= 1'b1;
   end

   assign waiting = memrq & mbusy;

   a_one_cycle_kind: assert property (@(posedge clk) disable iff (reset)
      !(rdcyc && wrcyc));

   // memory answers only a cycle this block opened
   a_ack_when_busy: assert property (@(posedge clk) disable iff (reset)
      memack |-> mbusy);

endmodule

`default_nettype wire

// File: design/main_memory.sv
/* 2048-word memory, one cycle per rising memrq
   memack pulses MEM_LATENCY cycles later (1 to 8) with read_data valid;
   address and data are captured when the cycle begins */
`timescale 1ns/100ps
`default_nettype none

module main_memory
#(
   parameter int MEM_LATENCY = 3
)
(
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  memrq,
   input  wire                  rdcyc,
   input  wire                  wrcyc,
   input  wire vmem_pkg::paddr_t paddr,
   input  wire vmem_pkg::word_t write_data,
   output logic                 memack,
   output vmem_pkg::word_t      read_data
);
   import vmem_pkg::*;

   localparam int DEPTH = 2 ** (PPAGE_W + OFFSET_W);
   localparam int CNT_W = $clog2(MEM_LATENCY + 1);

   if (MEM_LATENCY < 1 || MEM_LATENCY > 8)
   begin : g_bad_latency
      $error("MEM_LATENCY must be 1 to 8");
   end

   word_t            mem [DEPTH];
   paddr_t           addr_q;
   word_t            wdata_q;
   logic             write_q;
   logic             memrq_q;
   logic             start;
   logic [CNT_W-1:0] count;

   // cycle opens on the memrq edge
   assign start = memrq & ~memrq_q & (rdcyc | wrcyc);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         memrq_q <= 1'b0;
         write_q <= 1'b0;
         count   <= '0;
      end
      else
      begin
         memrq_q <= memrq;
         if (start)
         begin
            write_q <= wrcyc;
            count   <= CNT_W'(MEM_LATENCY);
         end
         else if (count != '0)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         addr_q  <= paddr;
         wdata_q <= write_data;
      end
   end

   // last count is the ack cycle
   assign memack = (count == CNT_W'(1));

   always_ff @(posedge clk)
   begin
      if (memack && write_q)
         mem[addr_q] <= wdata_q;
   end

   assign read_data = mem[addr_q];

   // controller opens one cycle at a time with its kind already set
   a_clean_start: assert property (@(posedge clk) disable iff (reset)
      $rose(memrq) |-> ((rdcyc ^ wrcyc) && (count == '0)));

endmodule

`default_nettype wire

// File: design/vmem_subsys_top.sv
/* virtual memory access path: state ring, page map, cycle control, memory
   done or fault pulses once per request; read_data is valid with done */
`timescale 1ns/100ps
`default_nettype none

module vmem_subsys_top
#(
   parameter int MEM_LATENCY = 3
)
(
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       mem_rd,
   input  wire                       mem_wr,
   input  wire                       map_wr,
   input  wire vmem_pkg::vaddr_t     vma,
   input  wire vmem_pkg::word_t      write_data,
   input  wire vmem_pkg::page_t      map_page,
   input  wire vmem_pkg::map_entry_t map_data,
   output vmem_pkg::word_t           read_data,
   output logic                      done,
   output logic                      fault
);
   import vmem_pkg::*;

   cpu_state_t state;
   ppage_t     phys_page;
   paddr_t     paddr;
   word_t      mem_rdata;
   logic       waiting;
   logic       access_ok;
   logic       write_ok;
   logic       memprepare;
   logic       memstart;
   logic       memcheck;
   logic       memrq;
   logic       rdcyc;
   logic       wrcyc;
   logic       vmaok;
   logic       mbusy;
   logic       memack;
   logic       check_q;

   // physical page replaces the virtual page
   assign paddr = {phys_page, vma[OFFSET_W-1:0]};

   cpu_state_ring u_ring
   (
      .clk     (clk),
      .reset   (reset),
      .waiting (waiting),
      .state   (state)
   );

   vmem_map u_map
   (
      .clk       (clk),
      .reset     (reset),
      .map_wr    (map_wr),
      .map_page  (map_page),
      .map_data  (map_data),
      .page      (vma[PAGE_W+OFFSET_W-1:OFFSET_W]),
      .access_ok (access_ok),
      .write_ok  (write_ok),
      .phys_page (phys_page)
   );

   vmem_ctrl u_ctrl
   (
      .clk        (clk),
      .reset      (reset),
      .state      (state),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .access_ok  (access_ok),
      .write_ok   (write_ok),
      .memack     (memack),
      .memprepare (memprepare),
      .memstart   (memstart),
      .memcheck   (memcheck),
      .memrq      (memrq),
      .rdcyc      (rdcyc),
      .wrcyc      (wrcyc),
      .vmaok      (vmaok),
      .mbusy      (mbusy),
      .waiting    (waiting)
   );

   main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_mem
   (
      .clk        (clk),
      .reset      (reset),
      .memrq      (memrq),
      .rdcyc      (rdcyc),
      .wrcyc      (wrcyc),
      .paddr      (paddr),
      .write_data (write_data),
      .memack     (memack),
      .read_data  (mem_rdata)
   );

   // fault follows the final check once vmaok has settled
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         check_q <= 1'b0;
         done    <= 1'b0;
         fault   <= 1'b0;
      end
      else
      begin
         check_q <= memcheck & ~memstart;
         done    <= memack;
         fault   <= check_q & ~vmaok;
      end
   end

   always_ff @(posedge clk)
   begin
      if (memack)
         read_data <= mem_rdata;
   end

   // no new request enters while a memory cycle is open
   a_no_overlap: assert property (@(posedge clk) disable iff (reset)
      !(memprepare && mbusy));

endmodule

`default_nettype wire

// File: bench/tb_vmem_subsys.sv
/* self-checking bench for the virtual memory path, one request at a time
   expected results come from bench copies of the map and of memory;
   data is only read back from addresses written earlier in the run */
`timescale 1ns/100ps
`default_nettype none

module tb_vmem_subsys;
   import vmem_pkg::*;

   localparam int MEM_LATENCY  = 3;
   localparam int SWEEP_CYCLES = 16;
   localparam int RESET_READS  = 6;
   localparam int WR_PAIRS     = 8;
   localparam int RO_WORDS     = 4;
   localparam int ALIAS_PAIRS  = 4;
   localparam int NUM_REQUESTS = RESET_READS + 2 * WR_PAIRS + 3 + 2 * RO_WORDS + 2 * ALIAS_PAIRS;
   // reset, map sweep and the map loads
   localparam int SETUP_CYCLES   = SWEEP_CYCLES + 48;
   localparam int TIMEOUT_CYCLES = NUM_REQUESTS * (8 + MEM_LATENCY) * 4 + SETUP_CYCLES;
   localparam int MEM_WORDS      = 2 ** (PPAGE_W + OFFSET_W);

   logic       clk;
   logic       reset;
   logic       mem_rd;
   logic       mem_wr;
   logic       map_wr;
   vaddr_t     vma;
   word_t      write_data;
   page_t      map_page;
   map_entry_t map_data;
   word_t      read_data;
   logic       done;
   logic       fault;

   // bench copies of the map and the memory
   map_entry_t ref_map [2 ** PAGE_W];
   word_t      ref_mem [MEM_WORDS];

   logic [15:0] lfsr_state = 16'd54575;
   vaddr_t      addr_list [$];
   string       cur_test;
   logic        exp_fault;
   logic        exp_is_read;
   word_t       exp_data;
   int          req_count = 0;
   int          resp_count = 0;
   int          err_count = 0;
   int          test_err_base = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          cycle_count;

   vmem_subsys_top #(.MEM_LATENCY(MEM_LATENCY)) u_vmem_subsys_top
   (
      .clk        (clk),
      .reset      (reset),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .map_wr     (map_wr),
      .vma        (vma),
      .write_data (write_data),
      .map_page   (map_page),
      .map_data   (map_data),
      .read_data  (read_data),
      .done       (done),
      .fault      (fault)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one step per bit taken
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] bits;
      int          i;
      bits = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         bits = {bits[14:0], lfsr_state[0]};
      end
      return bits;
   endfunction

   function automatic map_entry_t make_entry(input logic access, input logic wr,
                                             input ppage_t phys);
      map_entry_t ent;
      ent = '0;
      ent[MAP_ACCESS_BIT] = access;
      ent[MAP_WRITE_BIT]  = wr;
      ent[PPAGE_W-1:0]    = phys;
      return ent;
   endfunction

   function automatic paddr_t phys_addr(input vaddr_t addr);
      map_entry_t ent;
      ent = ref_map[addr[PAGE_W+OFFSET_W-1:OFFSET_W]];
      return {ent[PPAGE_W-1:0], addr[OFFSET_W-1:0]};
   endfunction

   // fault flag above the read data
   // reads need access and writes need access and write
   function automatic logic [WORD_W:0] expected_result(input logic is_write,
                                                       input vaddr_t addr);
      map_entry_t ent;
      ent = ref_map[addr[PAGE_W+OFFSET_W-1:OFFSET_W]];
      if (!ent[MAP_ACCESS_BIT] || (is_write && !ent[MAP_WRITE_BIT]))
         return {1'b1, word_t'(0)};
      else if (is_write)
         return {1'b0, word_t'(0)};
      else
         return {1'b0, ref_mem[phys_addr(addr)]};
   endfunction

   task automatic load_map(input page_t page, input map_entry_t entry);
      @(posedge clk);
      map_wr   <= 1'b1;
      map_page <= page;
      map_data <= entry;
      @(posedge clk);
      map_wr   <= 1'b0;
      ref_map[page] = entry;
   endtask

   task automatic run_request(input logic is_write, input vaddr_t addr, input word_t wdata);
      logic [WORD_W:0] expect_val;
      int              seen;
      expect_val = expected_result(is_write, addr);
      seen       = resp_count;
      @(posedge clk);
      mem_rd      <= !is_write;
      mem_wr      <= is_write;
      vma         <= addr;
      write_data  <= wdata;
      exp_fault   <= expect_val[WORD_W];
      exp_data    <= expect_val[WORD_W-1:0];
      exp_is_read <= !is_write;
      req_count   <= req_count + 1;
      // held until the compare process has counted done or fault
      while (resp_count == seen)
         @(posedge clk);
      mem_rd <= 1'b0;
      mem_wr <= 1'b0;
      if (is_write && !expect_val[WORD_W])
         ref_mem[phys_addr(addr)] = wdata;
      // idle gap where a stray second pulse would land
      repeat (2)
         @(posedge clk);
   endtask

   task automatic start_test(input string name);
      cur_test      = name;
      test_err_base = err_count;
   endtask

   task automatic finish_test();
      tests_run++;
      if (err_count == test_err_base)
         $display("[PASS] %s", cur_test);
      else
      begin
         tests_failed++;
         $display("[FAIL] %s: %0d errors", cur_test, err_count - test_err_base);
      end
   endtask

   // checks every done or fault against the open request
   always @(posedge clk)
   begin
      if (!reset && (done || fault))
      begin
         resp_count <= resp_count + 1;
         assert (!(done && fault))
         else
         begin
            $display("%s: done and fault pulsed in the same cycle", cur_test);
            err_count++;
         end
         assert (resp_count < req_count)
         else
         begin
            $display("%s: response pulse with no request outstanding", cur_test);
            err_count++;
         end
         assert (fault == exp_fault)
         else
         begin
            $display("FAILED %s: expected %s, actual %s", cur_test,
                     exp_fault ? "fault" : "done", fault ? "fault" : "done");
            err_count++;
         end
         if (done && exp_is_read && !exp_fault)
         begin
            assert (read_data === exp_data)
            else
            begin
               $display("FAILED %s: expected 0x%h, actual 0x%h", cur_test, exp_data, read_data);
               err_count++;
            end
         end
      end
   end

   initial
   begin : watchdog
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles in %s, no response from the DUT", cycle_count, cur_test);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      logic [15:0] r;
      word_t       d;
      vaddr_t      a;
      page_t       wr_page;
      logic        count_mismatch;
      int          i;
      count_mismatch = 1'b0;
      reset      <= 1'b1;
      mem_rd     <= 1'b0;
      mem_wr     <= 1'b0;
      map_wr     <= 1'b0;
      vma        <= '0;
      write_data <= '0;
      map_page   <= '0;
      map_data   <= '0;
      for (i = 0; i < 2 ** PAGE_W; i++)
         ref_map[i] = '0;
      repeat (3)
         @(posedge clk);
      reset <= 1'b0;
      repeat (SWEEP_CYCLES + 4)
         @(posedge clk);

      start_test("reset_faults");
      for (i = 0; i < RESET_READS; i++)
      begin
         r = take_bits(PAGE_W + OFFSET_W);
         run_request(1'b0, r[11:0], '0);
      end
      finish_test();

      // pages 0 to 3 on physical pages 7 to 4
      start_test("write_read");
      for (i = 0; i < 4; i++)
         load_map(page_t'(i), make_entry(1'b1, 1'b1, ppage_t'(7 - i)));
      addr_list.delete();
      for (i = 0; i < WR_PAIRS; i++)
      begin
         r = take_bits(2 + OFFSET_W);
         a = vaddr_t'(r[9:0]);
         addr_list.push_back(a);
         run_request(1'b1, a, take_bits(WORD_W));
      end
      foreach (addr_list[k])
         run_request(1'b0, addr_list[k], '0);
      finish_test();

      start_test("write_protect");
      load_map(4'd5, make_entry(1'b1, 1'b1, 3'd2));
      r = take_bits(OFFSET_W);
      a = {4'd5, r[7:0]};
      d = take_bits(WORD_W);
      run_request(1'b1, a, d);
      load_map(4'd5, make_entry(1'b1, 1'b0, 3'd2));
      run_request(1'b1, a, ~d);
      run_request(1'b0, a, '0);
      finish_test();

      start_test("read_only");
      load_map(4'd9, make_entry(1'b1, 1'b1, 3'd1));
      addr_list.delete();
      for (i = 0; i < RO_WORDS; i++)
      begin
         r = take_bits(OFFSET_W);
         a = {4'd9, r[7:0]};
         addr_list.push_back(a);
         run_request(1'b1, a, take_bits(WORD_W));
      end
      load_map(4'd9, make_entry(1'b1, 1'b0, 3'd1));
      foreach (addr_list[k])
         run_request(1'b0, addr_list[k], '0);
      finish_test();

      // pages 12 and 13 share physical page 0
      start_test("alias");
      load_map(4'd12, make_entry(1'b1, 1'b1, 3'd0));
      load_map(4'd13, make_entry(1'b1, 1'b1, 3'd0));
      for (i = 0; i < ALIAS_PAIRS; i++)
      begin
         r = take_bits(OFFSET_W);
         wr_page = i[0] ? 4'd13 : 4'd12;
         run_request(1'b1, {wr_page, r[7:0]}, take_bits(WORD_W));
         run_request(1'b0, {wr_page ^ 4'd1, r[7:0]}, '0);
      end
      finish_test();

      repeat (10)
         @(posedge clk);
      assert (resp_count == req_count)
      else
      begin
         $display("%0d requests got %0d responses", req_count, resp_count);
         count_mismatch = 1'b1;
      end
      $display("%0d tests run, %0d failing, %0d requests, %0d errors",
               tests_run, tests_failed, req_count, err_count);
      if (err_count == 0 && !count_mismatch)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
design/vmem_pkg.sv
design/cpu_state_ring.sv
design/vmem_map.sv
design/vmem_ctrl.sv
design/main_memory.sv
design/vmem_subsys_top.sv
bench/tb_vmem_subsys.sv

// File: Makefile
# Verilator build, run, lint and clean for the virtual memory testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS ?= --lint-only --timing -Wall --timescale 1ns/100ps
TOP       := tb_vmem_subsys
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
